/* logic/alu.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module alu (
    input  rv_pkg::alu_op_e     op_i,
    input  logic [`RV_XLEN-1:0] a_i,
    input  logic [`RV_XLEN-1:0] b_i,
    output logic [`RV_XLEN-1:0] result_o
);

    logic lt;

    // signed compare for slt
    assign lt = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD: result_o = a_i + b_i;
            rv_pkg::ALU_SUB: result_o = a_i - b_i;
            rv_pkg::ALU_AND: result_o = a_i & b_i;
            rv_pkg::ALU_OR:  result_o = a_i | b_i;
            rv_pkg::ALU_XOR: result_o = a_i ^ b_i;
            rv_pkg::ALU_SLT: result_o = {{(`RV_XLEN-1){1'b0}}, lt};
            default:         result_o = '0;
        endcase
    end

endmodule

/* logic/core_ctrl_fsm.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module core_ctrl_fsm (
    input  logic               clk,
    input  logic               rst,
    input  logic [6:0]         opcode_i,
    input  logic [2:0]         funct3_i,
    input  logic               branch_taken_i,
    input  logic               imem_resp_i,
    input  logic               dmem_resp_i,
    output rv_pkg::ctrl_word_t ctrl_o,
    output logic               imem_read_o,
    output logic               dmem_read_o,
    output logic               dmem_write_o,
    output logic               ld_ir_o,
    output logic               ld_operands_o,
    output logic               ld_result_o,
    output logic               ld_mdr_o,
    output logic               writeback_o,
    output logic               retire_o
);

    rv_pkg::ctrl_state_e state_q;
    rv_pkg::ctrl_state_e state_d;
    rv_pkg::ctrl_word_t  ctrl;
    logic                imem_read_q;
    logic                dmem_read_q;
    logic                dmem_write_q;
    logic                fetch_done;
    logic                mem_done;

    function automatic rv_pkg::alu_op_e alu_from_f3(input logic [2:0] f3);
        rv_pkg::alu_op_e op;
        case (f3)
            `RV_F3_SLT: op = rv_pkg::ALU_SLT;
            `RV_F3_XOR: op = rv_pkg::ALU_XOR;
            `RV_F3_OR:  op = rv_pkg::ALU_OR;
            `RV_F3_AND: op = rv_pkg::ALU_AND;
            default:    op = rv_pkg::ALU_ADD;
        endcase
        return op;
    endfunction

    // decode from the held IR; stable for the whole instruction
    always_comb begin
        ctrl = '0;
        ctrl.alu_op = rv_pkg::ALU_ADD;
        case (opcode_i)
            `RV_OP_LUI: begin
                ctrl.is_lui = 1'b1;
                ctrl.load_regfile = 1'b1;
            end
            `RV_OP_IMM: begin
                ctrl.alu_op = alu_from_f3(funct3_i);
                ctrl.use_imm = 1'b1;
                ctrl.load_regfile = 1'b1;
            end
            `RV_OP_REG: begin
                ctrl.alu_op = alu_from_f3(funct3_i);
                ctrl.load_regfile = 1'b1;
            end
            `RV_OP_LOAD: begin
                ctrl.use_imm = 1'b1;
                ctrl.is_load = 1'b1;
                ctrl.load_regfile = 1'b1;
            end
            `RV_OP_STORE: begin
                ctrl.use_imm = 1'b1;
                ctrl.is_store = 1'b1;
            end
            // decision is registered in execute, used at writeback
            `RV_OP_BRANCH: ctrl.is_branch = branch_taken_i;
            `RV_OP_JAL: begin
                ctrl.is_jal = 1'b1;
                ctrl.load_regfile = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // responses only count while a request is held
    assign fetch_done = imem_read_q && imem_resp_i;
    assign mem_done   = (dmem_read_q || dmem_write_q) && dmem_resp_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            rv_pkg::FETCH:     if (fetch_done) state_d = rv_pkg::DECODE;
            rv_pkg::DECODE:    state_d = rv_pkg::EXECUTE;
            rv_pkg::EXECUTE: begin
                if (ctrl.is_load || ctrl.is_store) begin
                    state_d = rv_pkg::MEMORY;
                end else begin
                    state_d = rv_pkg::WRITEBACK;
                end
            end
            rv_pkg::MEMORY:    if (mem_done) state_d = rv_pkg::WRITEBACK;
            rv_pkg::WRITEBACK: state_d = rv_pkg::FETCH;
            default:           state_d = rv_pkg::FETCH;
        endcase
    end

    // request levels are registered so they stay low through reset
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= rv_pkg::FETCH;
            imem_read_q  <= 1'b0;
            dmem_read_q  <= 1'b0;
            dmem_write_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            imem_read_q  <= (state_d == rv_pkg::FETCH);
            dmem_read_q  <= (state_d == rv_pkg::MEMORY) && ctrl.is_load;
            dmem_write_q <= (state_d == rv_pkg::MEMORY) && ctrl.is_store;
        end
    end

    assign ctrl_o        = ctrl;
    assign imem_read_o   = imem_read_q;
    assign dmem_read_o   = dmem_read_q;
    assign dmem_write_o  = dmem_write_q;
    assign ld_ir_o       = (state_q == rv_pkg::FETCH) && fetch_done;
    assign ld_operands_o = (state_q == rv_pkg::DECODE);
    assign ld_result_o   = (state_q == rv_pkg::EXECUTE);
    assign ld_mdr_o      = (state_q == rv_pkg::MEMORY) && dmem_read_q && dmem_resp_i;
    assign writeback_o   = (state_q == rv_pkg::WRITEBACK);
    assign retire_o      = (state_q == rv_pkg::WRITEBACK);

endmodule

/* logic/datapath.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module datapath (
    input  logic                clk,
    input  logic                rst,
    input  rv_pkg::ctrl_word_t  ctrl_i,
    input  logic                ld_ir_i,
    input  logic                ld_operands_i,
    input  logic                ld_result_i,
    input  logic                ld_mdr_i,
    input  logic                writeback_i,
    input  logic [`RV_XLEN-1:0] imem_rdata_i,
    input  logic [`RV_XLEN-1:0] dmem_rdata_i,
    output logic [`RV_XLEN-1:0] imem_address_o,
    output logic [`RV_XLEN-1:0] dmem_address_o,
    output logic [`RV_XLEN-1:0] dmem_wdata_o,
    output logic [6:0]          opcode_o,
    output logic [2:0]          funct3_o,
    output logic                branch_taken_o,
    output rv_pkg::retire_rec_t rec_o
);

    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] ir_q;
    logic [`RV_XLEN-1:0] rs1_q;
    logic [`RV_XLEN-1:0] rs2_q;
    logic [`RV_XLEN-1:0] result_q;
    logic [`RV_XLEN-1:0] mdr_q;
    logic                taken_q;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_next;
    logic [`RV_XLEN-1:0] wb_data;
    logic [4:0]          rd;
    logic                taken;
    logic                we;
    rv_pkg::alu_op_e     alu_op;

    assign opcode_o = ir_q[6:0];
    assign funct3_o = ir_q[14:12];
    assign rd       = ir_q[11:7];

    assign imm_i = {{20{ir_q[31]}}, ir_q[31:20]};
    assign imm_s = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
    assign imm_b = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
    assign imm_u = {ir_q[31:12], 12'h000};
    assign imm_j = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};

    reg_file i_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rs1_i      (ir_q[19:15]),
        .rs2_i      (ir_q[24:20]),
        .rd_i       (rd),
        .wdata_i    (wb_data),
        .we_i       (we),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // funct7 bit 30 picks sub over add for register ops
    assign alu_op = (opcode_o == `RV_OP_REG && ctrl_i.alu_op == rv_pkg::ALU_ADD && ir_q[30])
                  ? rv_pkg::ALU_SUB : ctrl_i.alu_op;
    assign alu_b  = !ctrl_i.use_imm ? rs2_q : (ctrl_i.is_store ? imm_s : imm_i);

    alu i_alu (
        .op_i     (alu_op),
        .a_i      (rs1_q),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    always_comb begin
        case (funct3_o)
            `RV_F3_BEQ: taken = (rs1_q == rs2_q);
            `RV_F3_BNE: taken = (rs1_q != rs2_q);
            default:    taken = 1'b0;
        endcase
    end

    assign pc_plus4 = pc_q + 32'd4;

    always_comb begin
        if (ctrl_i.is_jal) begin
            pc_next = pc_q + imm_j;
        end else if (ctrl_i.is_branch) begin
            pc_next = pc_q + imm_b;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_comb begin
        if (ctrl_i.is_lui) begin
            wb_data = imm_u;
        end else if (ctrl_i.is_jal) begin
            wb_data = pc_plus4;
        end else if (ctrl_i.is_load) begin
            wb_data = mdr_q;
        end else begin
            wb_data = result_q;
        end
    end

    assign we = writeback_i && ctrl_i.load_regfile;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q     <= `RV_RESET_PC;
            ir_q     <= '0;
            rs1_q    <= '0;
            rs2_q    <= '0;
            result_q <= '0;
            mdr_q    <= '0;
            taken_q  <= 1'b0;
        end else begin
            if (ld_ir_i) ir_q <= imem_rdata_i;
            if (ld_operands_i) begin
                rs1_q <= rs1_data;
                rs2_q <= rs2_data;
            end
            if (ld_result_i) begin
                result_q <= alu_result;
                taken_q  <= taken;
            end
            if (ld_mdr_i) mdr_q <= dmem_rdata_i;
            if (writeback_i) pc_q <= pc_next;
        end
    end

    assign imem_address_o = pc_q;
    assign dmem_address_o = result_q;
    assign dmem_wdata_o   = rs2_q;
    assign branch_taken_o = taken_q;

    // record as seen during writeback; order is filled by the monitor
    always_comb begin
        rec_o           = '0;
        rec_o.inst      = ir_q;
        rec_o.pc_rdata  = pc_q;
        rec_o.pc_wdata  = pc_next;
        rec_o.rd_addr   = ctrl_i.load_regfile ? rd : 5'd0;
        rec_o.rd_wdata  = (rec_o.rd_addr != 5'd0) ? wb_data : '0;
        if (ctrl_i.is_load || ctrl_i.is_store) rec_o.mem_addr = result_q;
        if (ctrl_i.is_load) begin
            rec_o.mem_rmask = 4'hf;
            rec_o.mem_rdata = mdr_q;
        end
        if (ctrl_i.is_store) begin
            rec_o.mem_wmask = 4'hf;
            rec_o.mem_wdata = rs2_q;
        end
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          rs1_i,
    input  logic [4:0]          rs2_i,
    input  logic [4:0]          rd_i,
    input  logic [`RV_XLEN-1:0] wdata_i,
    input  logic                we_i,
    output logic [`RV_XLEN-1:0] rs1_data_o,
    output logic [`RV_XLEN-1:0] rs2_data_o
);

    logic [`RV_XLEN-1:0] regs [32];

    // x0 is cleared at reset and never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

endmodule

/* logic/retire_monitor.sv */
`timescale 1ns/1ns

module retire_monitor (
    input  logic                clk,
    input  logic                rst,
    input  logic                retire_i,
    input  rv_pkg::retire_rec_t rec_i,
    output rv_pkg::retire_rec_t trace_o,
    output logic                trace_valid_o
);

    logic [63:0]         order_q;
    rv_pkg::retire_rec_t trace_q;
    logic                valid_q;

    // first retirement carries order zero
    always_ff @(posedge clk) begin
        if (rst) begin
            order_q <= 64'd0;
            trace_q <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= retire_i;
            if (retire_i) begin
                trace_q       <= rec_i;
                trace_q.order <= order_q;
                order_q       <= order_q + 64'd1;
            end
        end
    end

    assign trace_o       = trace_q;
    assign trace_valid_o = valid_q;

endmodule

/* logic/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// word width for data, addresses and instructions
`define RV_XLEN      32
`define RV_RESET_PC  32'h0000_0000

// major opcodes of the supported subset
`define RV_OP_LUI    7'b0110111
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111

// funct3 for alu and branch decode
`define RV_F3_ADD    3'b000
`define RV_F3_SLT    3'b010
`define RV_F3_XOR    3'b100
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111
`define RV_F3_BEQ    3'b000
`define RV_F3_BNE    3'b001

`endif

/* logic/rv_core_top.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_core_top (
    input  logic                clk,
    input  logic                rst,
    output logic [`RV_XLEN-1:0] imem_address_o,
    output logic                imem_read_o,
    input  logic [`RV_XLEN-1:0] imem_rdata_i,
    input  logic                imem_resp_i,
    output logic [`RV_XLEN-1:0] dmem_address_o,
    output logic                dmem_read_o,
    output logic                dmem_write_o,
    output logic [`RV_XLEN-1:0] dmem_wdata_o,
    input  logic [`RV_XLEN-1:0] dmem_rdata_i,
    input  logic                dmem_resp_i,
    output rv_pkg::retire_rec_t trace_o,
    output logic                trace_valid_o
);

    rv_pkg::ctrl_word_t  ctrl;
    rv_pkg::retire_rec_t rec;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                branch_taken;
    logic                ld_ir;
    logic                ld_operands;
    logic                ld_result;
    logic                ld_mdr;
    logic                writeback;
    logic                retire;

    core_ctrl_fsm i_core_ctrl_fsm (
        .clk            (clk),
        .rst            (rst),
        .opcode_i       (opcode),
        .funct3_i       (funct3),
        .branch_taken_i (branch_taken),
        .imem_resp_i    (imem_resp_i),
        .dmem_resp_i    (dmem_resp_i),
        .ctrl_o         (ctrl),
        .imem_read_o    (imem_read_o),
        .dmem_read_o    (dmem_read_o),
        .dmem_write_o   (dmem_write_o),
        .ld_ir_o        (ld_ir),
        .ld_operands_o  (ld_operands),
        .ld_result_o    (ld_result),
        .ld_mdr_o       (ld_mdr),
        .writeback_o    (writeback),
        .retire_o       (retire)
    );

    datapath i_datapath (
        .clk            (clk),
        .rst            (rst),
        .ctrl_i         (ctrl),
        .ld_ir_i        (ld_ir),
        .ld_operands_i  (ld_operands),
        .ld_result_i    (ld_result),
        .ld_mdr_i       (ld_mdr),
        .writeback_i    (writeback),
        .imem_rdata_i   (imem_rdata_i),
        .dmem_rdata_i   (dmem_rdata_i),
        .imem_address_o (imem_address_o),
        .dmem_address_o (dmem_address_o),
        .dmem_wdata_o   (dmem_wdata_o),
        .opcode_o       (opcode),
        .funct3_o       (funct3),
        .branch_taken_o (branch_taken),
        .rec_o          (rec)
    );

    retire_monitor i_retire_monitor (
        .clk           (clk),
        .rst           (rst),
        .retire_i      (retire),
        .rec_i         (rec),
        .trace_o       (trace_o),
        .trace_valid_o (trace_valid_o)
    );

endmodule

/* logic/rv_pkg.sv */
`include "rv_consts.svh"

package rv_pkg;

    // multicycle sequencing, one instruction in flight
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4
    } ctrl_state_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        // second alu operand from the immediate
        logic    use_imm;
        logic    load_regfile;
        logic    is_load;
        logic    is_store;
        // conditional branch that resolved taken
        logic    is_branch;
        logic    is_jal;
        logic    is_lui;
    } ctrl_word_t;

    // one retired instruction, as seen by the trace port
    typedef struct packed {
        logic [63:0]          order;
        logic [`RV_XLEN-1:0]  inst;
        logic [`RV_XLEN-1:0]  pc_rdata;
        logic [`RV_XLEN-1:0]  pc_wdata;
        logic [4:0]           rd_addr;
        logic [`RV_XLEN-1:0]  rd_wdata;
        logic [`RV_XLEN-1:0]  mem_addr;
        logic [3:0]           mem_rmask;
        logic [3:0]           mem_wmask;
        logic [`RV_XLEN-1:0]  mem_rdata;
        logic [`RV_XLEN-1:0]  mem_wdata;
    } retire_rec_t;

endpackage

/* run.sh */
#!/bin/sh
# build and run the rv_core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns --top-module tb_rv_core -f rv_core.f

out=$(./obj_dir/Vtb_rv_core)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Test passed'; then
    exit 0
fi
exit 1

/* rv_core.f */
+incdir+logic
+incdir+test
logic/rv_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/core_ctrl_fsm.sv
logic/datapath.sv
logic/retire_monitor.sv
logic/rv_core_top.sv
test/tb_rv_core.sv

/* test/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// one row per retirement, in retirement order
// columns are inst, pc_rdata, pc_wdata, rd_addr, rd_wdata, mem_addr and mem_data
// mem_data is the stored word for sw and the loaded word for lw
localparam int num_rows = 23;

localparam row_t prog_rows [num_rows] = '{
    // lui and immediate alu ops
    '{32'h123450b7, 32'h00, 32'h04, 5'd1, 32'h12345000, 32'h0, 32'h0},
    '{32'h10000113, 32'h04, 32'h08, 5'd2, 32'h00000100, 32'h0, 32'h0},
    '{32'hffb00193, 32'h08, 32'h0c, 5'd3, 32'hfffffffb, 32'h0, 32'h0},
    '{32'h0011a213, 32'h0c, 32'h10, 5'd4, 32'h00000001, 32'h0, 32'h0},
    '{32'h0ff0c293, 32'h10, 32'h14, 5'd5, 32'h123450ff, 32'h0, 32'h0},
    '{32'h00f16313, 32'h14, 32'h18, 5'd6, 32'h0000010f, 32'h0, 32'h0},
    '{32'h0f02f393, 32'h18, 32'h1c, 5'd7, 32'h000000f0, 32'h0, 32'h0},
    // register alu ops
    '{32'h00708433, 32'h1c, 32'h20, 5'd8, 32'h123450f0, 32'h0, 32'h0},
    '{32'h403104b3, 32'h20, 32'h24, 5'd9, 32'h00000105, 32'h0, 32'h0},
    '{32'h00312533, 32'h24, 32'h28, 5'd10, 32'h00000000, 32'h0, 32'h0},
    '{32'h0062f5b3, 32'h28, 32'h2c, 5'd11, 32'h0000000f, 32'h0, 32'h0},
    '{32'h00a3e633, 32'h2c, 32'h30, 5'd12, 32'h000000f0, 32'h0, 32'h0},
    '{32'h0080c6b3, 32'h30, 32'h34, 5'd13, 32'h000000f0, 32'h0, 32'h0},
    // addi into x0, then x0 as a source
    '{32'h00708013, 32'h34, 32'h38, 5'd0, 32'h00000000, 32'h0, 32'h0},
    '{32'h00200733, 32'h38, 32'h3c, 5'd14, 32'h00000100, 32'h0, 32'h0},
    // sw then lw at 0x104
    '{32'h00812223, 32'h3c, 32'h40, 5'd0, 32'h00000000, 32'h104, 32'h123450f0},
    '{32'h00412783, 32'h40, 32'h44, 5'd15, 32'h123450f0, 32'h104, 32'h123450f0},
    // beq taken skips 0x48, bne not taken, bne taken, beq not taken
    '{32'h00878463, 32'h44, 32'h4c, 5'd0, 32'h00000000, 32'h0, 32'h0},
    '{32'h00879463, 32'h4c, 32'h50, 5'd0, 32'h00000000, 32'h0, 32'h0},
    '{32'h00311663, 32'h50, 32'h5c, 5'd0, 32'h00000000, 32'h0, 32'h0},
    '{32'h00208463, 32'h5c, 32'h60, 5'd0, 32'h00000000, 32'h0, 32'h0},
    // jal links x1 and jumps over 0x64..0x6c
    '{32'h010000ef, 32'h60, 32'h70, 5'd1, 32'h00000064, 32'h0, 32'h0},
    '{32'h00108813, 32'h70, 32'h74, 5'd16, 32'h00000065, 32'h0, 32'h0}
};

`endif

/* test/tb_rv_core.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module tb_rv_core;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc_rdata;
        logic [31:0] pc_wdata;
        logic [4:0]  rd_addr;
        logic [31:0] rd_wdata;
        logic [31:0] mem_addr;
        logic [31:0] mem_data;
    } row_t;

    `include "tb_program.svh"

    localparam int mem_words = 128;
    localparam int timeout_cycles = 60;

    logic                clk = 1'b0;
    logic                rst;
    logic [31:0]         imem_address;
    logic                imem_read;
    logic [31:0]         imem_rdata;
    logic                imem_resp;
    logic [31:0]         dmem_address;
    logic                dmem_read;
    logic                dmem_write;
    logic [31:0]         dmem_wdata;
    logic [31:0]         dmem_rdata;
    logic                dmem_resp;
    rv_pkg::retire_rec_t trace;
    logic                trace_valid;

    logic [31:0] mem [mem_words];
    logic [31:0] rng_state;
    int          errors;
    int          dreq_count;
    logic        first_fetch_seen;
    logic [31:0] first_fetch_addr;
    logic [31:0] wr_addr_seen;
    logic [31:0] wr_data_seen;

    always #10 clk = ~clk;

    rv_core_top i_rv_core_top (
        .clk            (clk),
        .rst            (rst),
        .imem_address_o (imem_address),
        .imem_read_o    (imem_read),
        .imem_rdata_i   (imem_rdata),
        .imem_resp_i    (imem_resp),
        .dmem_address_o (dmem_address),
        .dmem_read_o    (dmem_read),
        .dmem_write_o   (dmem_write),
        .dmem_wdata_o   (dmem_wdata),
        .dmem_rdata_i   (dmem_rdata),
        .dmem_resp_i    (dmem_resp),
        .trace_o        (trace),
        .trace_valid_o  (trace_valid)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got_v,
                                 input logic [63:0] want_v);
        if (got_v !== want_v) begin
            $display("FAIL %s: got %h, expected %h", name, got_v, want_v);
            errors++;
        end
    endtask

    task automatic wait_for_retire(output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < timeout_cycles) begin
            @(posedge clk);
            seen = trace_valid;
            cycles++;
        end
    endtask

    // shared word memory behind both ports with 0 to 3 extra cycles per response
    initial begin : memory_model
        logic        i_busy;
        logic [1:0]  i_wait;
        logic [31:0] i_addr;
        logic        d_busy;
        logic [1:0]  d_wait;
        logic [31:0] d_addr;
        logic [31:0] d_wdata;
        logic        d_write;
        rng_state = 32'h0f25_8517;
        imem_rdata <= '0;
        imem_resp <= 1'b0;
        dmem_rdata <= '0;
        dmem_resp <= 1'b0;
        dreq_count <= 0;
        first_fetch_seen <= 1'b0;
        first_fetch_addr <= '0;
        wr_addr_seen <= '0;
        wr_data_seen <= '0;
        i_busy = 1'b0;
        i_wait = 2'd0;
        i_addr = '0;
        d_busy = 1'b0;
        d_wait = 2'd0;
        d_addr = '0;
        d_wdata = '0;
        d_write = 1'b0;
        for (int a = 0; a < mem_words; a++) begin
            mem[a] = 32'hdead_0000 | 32'(a);
        end
        for (int r = 0; r < num_rows; r++) begin
            mem[prog_rows[r].pc_rdata[8:2]] = prog_rows[r].inst;
        end
        forever begin
            @(posedge clk);
            if (rst) begin
                imem_resp <= 1'b0;
                dmem_resp <= 1'b0;
                i_busy = 1'b0;
                d_busy = 1'b0;
            end else begin
                // request drops on the same edge that consumes the pulse
                if (imem_resp) begin
                    imem_resp <= 1'b0;
                end else begin
                    if (!i_busy && imem_read) begin
                        i_busy = 1'b1;
                        rng_state = xorshift(rng_state);
                        i_wait = rng_state[1:0];
                        i_addr = imem_address;
                        if (!first_fetch_seen) begin
                            first_fetch_seen <= 1'b1;
                            first_fetch_addr <= imem_address;
                        end
                    end
                    if (i_busy) begin
                        if (i_wait == 2'd0) begin
                            imem_rdata <= mem[i_addr[8:2]];
                            imem_resp <= 1'b1;
                            i_busy = 1'b0;
                        end else begin
                            i_wait = i_wait - 2'd1;
                        end
                    end
                end
                if (dmem_resp) begin
                    dmem_resp <= 1'b0;
                end else begin
                    if (!d_busy && (dmem_read || dmem_write)) begin
                        d_busy = 1'b1;
                        rng_state = xorshift(rng_state);
                        d_wait = rng_state[1:0];
                        d_addr = dmem_address;
                        d_wdata = dmem_wdata;
                        d_write = dmem_write;
                        dreq_count <= dreq_count + 1;
                        if (dmem_write) begin
                            wr_addr_seen <= dmem_address;
                            wr_data_seen <= dmem_wdata;
                        end
                    end
                    if (d_busy) begin
                        if (d_wait == 2'd0) begin
                            if (d_write) begin
                                mem[d_addr[8:2]] = d_wdata;
                            end else begin
                                dmem_rdata <= mem[d_addr[8:2]];
                            end
                            dmem_resp <= 1'b1;
                            d_busy = 1'b0;
                        end else begin
                            d_wait = d_wait - 2'd1;
                        end
                    end
                end
            end
        end
    end

    initial begin : run_program
        rv_pkg::retire_rec_t got;
        row_t                want;
        logic [31:0]         prev_pc_wdata;
        int                  mem_rows;
        int                  row_errors;
        int                  checked;
        int                  timeouts;
        bit                  seen;
        bit                  is_load;
        bit                  is_store;
        errors = 0;
        mem_rows = 0;
        checked = 0;
        timeouts = 0;
        prev_pc_wdata = '0;
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < num_rows && timeouts == 0; i++) begin
            wait_for_retire(seen);
            if (!seen) begin
                $display("timed out waiting for instruction %0d to retire", i);
                timeouts++;
            end else begin
                got = trace;
                want = prog_rows[i];
                row_errors = errors;
                is_load = (want.inst[6:0] == `RV_OP_LOAD);
                is_store = (want.inst[6:0] == `RV_OP_STORE);
                if (is_load || is_store) begin
                    mem_rows++;
                end
                if (i == 0) begin
                    compare_value("first fetch address", 64'(first_fetch_addr),
                                  64'(`RV_RESET_PC));
                end else begin
                    compare_value("pc_rdata after pc_wdata", 64'(got.pc_rdata),
                                  64'(prev_pc_wdata));
                end
                compare_value("order", got.order, 64'(i));
                compare_value("inst", 64'(got.inst), 64'(want.inst));
                compare_value("pc_rdata", 64'(got.pc_rdata), 64'(want.pc_rdata));
                compare_value("pc_wdata", 64'(got.pc_wdata), 64'(want.pc_wdata));
                compare_value("rd_addr", 64'(got.rd_addr), 64'(want.rd_addr));
                compare_value("rd_wdata", 64'(got.rd_wdata), 64'(want.rd_wdata));
                compare_value("mem_addr", 64'(got.mem_addr), 64'(want.mem_addr));
                // data port stays quiet except for loads and stores
                compare_value("data requests", 64'(dreq_count), 64'(mem_rows));
                // full-word accesses only
                compare_value("mem_rmask", 64'(got.mem_rmask), is_load ? 64'hf : 64'h0);
                compare_value("mem_wmask", 64'(got.mem_wmask), is_store ? 64'hf : 64'h0);
                compare_value("mem_rdata", 64'(got.mem_rdata),
                              is_load ? 64'(want.mem_data) : 64'h0);
                compare_value("mem_wdata", 64'(got.mem_wdata),
                              is_store ? 64'(want.mem_data) : 64'h0);
                if (is_store) begin
                    compare_value("dmem_address_o", 64'(wr_addr_seen), 64'(want.mem_addr));
                    compare_value("dmem_wdata_o", 64'(wr_data_seen), 64'(want.mem_data));
                end
                prev_pc_wdata = got.pc_wdata;
                checked++;
                $display("instruction %0d at pc %h: %s", i, got.pc_rdata,
                         (errors == row_errors) ? "ok" : "mismatch");
            end
        end
        $display("checked %0d of %0d instructions, %0d mismatches, %0d timeouts",
                 checked, num_rows, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
